/* all.f */
design/npu_pkg.sv
design/inst_memory.sv
design/fetch_unit.sv
design/dispatch_unit.sv
design/matrix_add_engine.sv
design/bank_arbiter.sv
design/scratch_memory.sv
design/npu_top.sv
tests/npu_assertions.sv
tests/npu_checker.sv
tests/tb_npu.sv

/* tests/tb_npu.sv */
module tb_npu import npu_pkg::*; ();

    localparam int drive_delay  = 10;
    localparam int num_tests    = 6;
    localparam int total_insts  = 29;
    localparam int readback_len = num_banks * bank_depth;
    // two full source regions plus the longest streaming gap
    localparam int load_len     = 2 * 256 + 64;
    localparam int add_len      = 3 * 16 * 16 + 20;
    localparam int cycle_limit  = 2 * (16 + num_tests * (readback_len + 40)
                                     + total_insts * (load_len + add_len));

    logic                       CLOCK_50;
    logic                       reset;
    logic                       inst_write;
    logic [inst_addr_width-1:0] inst_addr;
    logic [inst_width-1:0]      inst_data;
    mem_req_t                   host_req;
    logic [data_width-1:0]      host_rdata;
    logic                       host_rvalid;
    logic                       npu_idle;

    logic [31:0]                lfsr;
    int                         cycle_count;
    int                         prog_ptr;
    int                         total_errors;
    logic [inst_width-1:0]      prog [$];
    logic [inst_width-1:0]      word;
    logic [opcode_width-1:0]    other_ops [5];

    npu_top i_npu_top (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .inst_write  (inst_write),
        .inst_addr   (inst_addr),
        .inst_data   (inst_data),
        .host_req    (host_req),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .npu_idle    (npu_idle)
    );

    npu_checker i_checker (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .inst_write  (inst_write),
        .inst_data   (inst_data),
        .host_req    (host_req),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    bind bank_arbiter npu_assertions i_npu_assertions (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .engine_req   (engine_req),
        .host_req     (host_req),
        .host_rvalid  (host_rvalid),
        .engine_busy  (tb_npu.i_npu_top.engine_busy),
        .engine_start (tb_npu.i_npu_top.start),
        .engine_done  (tb_npu.i_npu_top.engine_done)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("timeout after %0d cycles, the NPU never returned to idle", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------
    // galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [inst_width-1:0] encode(input logic [opcode_width-1:0] op,
                                                     input operand_t s1, input operand_t s2,
                                                     input operand_t d,
                                                     input logic [dim_width-1:0] rows,
                                                     input logic [dim_width-1:0] cols);
        logic [inst_width-1:0] w;
        w = '0;
        w[opcode_lsb +: opcode_width]      = op;
        w[src1_bank_lsb +: bank_sel_width] = s1.bank;
        w[src1_off_lsb +: bank_addr_width] = s1.offset;
        w[src2_bank_lsb +: bank_sel_width] = s2.bank;
        w[src2_off_lsb +: bank_addr_width] = s2.offset;
        w[dest_bank_lsb +: bank_sel_width] = d.bank;
        w[dest_off_lsb +: bank_addr_width] = d.offset;
        w[rows_lsb +: dim_width]           = rows;
        w[cols_lsb +: dim_width]           = cols;
        return w;
    endfunction

    task automatic step();
        @(posedge CLOCK_50);
        #drive_delay;
    endtask

    task automatic host_access(input logic wr, input logic [bank_sel_width-1:0] bank,
                               input logic [bank_addr_width-1:0] offset,
                               input logic [data_width-1:0] data);
        host_req.valid  = 1'b1;
        host_req.write  = wr;
        host_req.bank   = bank;
        host_req.offset = offset;
        host_req.wdata  = data;
        step();
        host_req = '0;
    endtask

    task automatic load_region(input operand_t loc, input int count);
        for (int i = 0; i < count; i++) begin
            host_access(1'b1, loc.bank, bank_addr_width'(loc.offset + i),
                        data_width'(lfsr_bits(data_width)));
        end
    endtask

    // zero word first so fetch parks right behind the new one
    task automatic put_inst(input logic [inst_width-1:0] w);
        inst_write = 1'b1;
        inst_addr  = inst_addr_width'(prog_ptr + 1);
        inst_data  = '0;
        step();
        inst_addr  = inst_addr_width'(prog_ptr);
        inst_data  = w;
        step();
        inst_write = 1'b0;
        prog_ptr++;
    endtask

    // a few cycles for fetch to see the last word before idle means anything
    task automatic wait_idle();
        repeat (4) step();
        while (!npu_idle) begin
            step();
        end
    endtask

    task automatic readback_all();
        for (int b = 0; b < num_banks; b++) begin
            for (int o = 0; o < bank_depth; o++) begin
                host_access(1'b0, bank_sel_width'(b), bank_addr_width'(o), '0);
            end
        end
        repeat (2) step();
    endtask

    task automatic rand_add(input logic [opcode_width-1:0] op, input bit overlap,
                            input bit full_size, output logic [inst_width-1:0] w);
        operand_t             s1;
        operand_t             s2;
        operand_t             d;
        logic [dim_width-1:0] rows;
        logic [dim_width-1:0] cols;
        s1.bank   = bank_sel_width'(lfsr_bits(bank_sel_width));
        s1.offset = bank_addr_width'(lfsr_bits(bank_addr_width));
        s2.bank   = bank_sel_width'(lfsr_bits(bank_sel_width));
        s2.offset = bank_addr_width'(lfsr_bits(bank_addr_width));
        d.bank    = bank_sel_width'(lfsr_bits(bank_sel_width));
        d.offset  = bank_addr_width'(lfsr_bits(bank_addr_width));
        rows      = full_size ? 5'd16 : dim_width'(lfsr_bits(dim_width) % 17);
        cols      = full_size ? 5'd16 : dim_width'(lfsr_bits(dim_width) % 17);
        if (overlap) begin
            // dest slides a few words either way over src1
            d.bank   = s1.bank;
            d.offset = s1.offset + bank_addr_width'(lfsr_bits(3)) - 10'd4;
        end
        if (op == op_add) begin
            load_region(s1, int'(rows) * int'(cols));
            load_region(s2, int'(rows) * int'(cols));
        end
        w = encode(op, s1, s2, d, rows, cols);
    endtask

    task automatic run_program(input int gap_bits);
        while (prog.size() > 0) begin
            put_inst(prog.pop_front());
            if (gap_bits > 0) begin
                repeat (lfsr_bits(gap_bits)) step();
            end
        end
    endtask

    task automatic close_test(input string name);
        wait_idle();
        readback_all();
        i_checker.report_test(name);
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        lfsr         = 32'd97056;
        reset        = 1'b1;
        inst_write   = 1'b0;
        inst_addr    = '0;
        inst_data    = '0;
        host_req     = '0;
        prog_ptr     = 0;
        cycle_count  = 0;
        other_ops    = '{op_conv, op_pool, op_relu, 4'd3, 4'd15};
        repeat (16) @(posedge CLOCK_50);
        #drive_delay;
        reset = 1'b0;
        wait_idle();

        rand_add(op_add, 1'b0, 1'b1, word);
        prog.push_back(word);
        run_program(0);
        close_test("single add");

        repeat (6) begin
            rand_add(op_add, 1'b0, 1'b0, word);
            prog.push_back(word);
        end
        run_program(0);
        close_test("random program");

        // the other opcodes carry random fields and must touch nothing
        repeat (6) begin
            rand_add(op_add, 1'b0, 1'b0, word);
            prog.push_back(word);
            rand_add(other_ops[lfsr_bits(3) % 5], 1'b0, 1'b0, word);
            prog.push_back(word);
        end
        run_program(0);
        close_test("dropped opcodes");

        repeat (4) begin
            rand_add(op_add, 1'b1, 1'b0, word);
            prog.push_back(word);
        end
        run_program(0);
        close_test("overlapping dest");

        repeat (6) begin
            rand_add(op_add, 1'b0, 1'b0, word);
            prog.push_back(word);
        end
        run_program(6);
        close_test("streaming");

        repeat (32) begin
            host_access(1'b1, bank_sel_width'(lfsr_bits(bank_sel_width)),
                        bank_addr_width'(lfsr_bits(bank_addr_width)),
                        data_width'(lfsr_bits(data_width)));
        end
        close_test("host readback");

        total_errors = i_checker.errors
                     + i_npu_top.i_bank_arbiter.i_npu_assertions.fail_count;
        $display("%0d tests, %0d failed, %0d reads checked, %0d errors, %0d assertion failures",
                 i_checker.tests_run, i_checker.tests_failed, i_checker.checks,
                 i_checker.errors, i_npu_top.i_bank_arbiter.i_npu_assertions.fail_count);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tests/npu_checker.sv */
module npu_checker import npu_pkg::*; (
    input logic                  CLOCK_50,
    input logic                  reset,
    input logic                  inst_write,
    input logic [inst_width-1:0] inst_data,
    input mem_req_t              host_req,
    input logic [data_width-1:0] host_rdata,
    input logic                  host_rvalid
);

    // every scratch bank as the host should see it
    logic [data_width-1:0]      model [num_banks][bank_depth];

    logic                       rd_pending;
    logic [data_width-1:0]      rd_expect;
    logic [bank_sel_width-1:0]  rd_bank;
    logic [bank_addr_width-1:0] rd_offset;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int errors_at_start;
    int checks_at_start;

    initial begin
        for (int b = 0; b < num_banks; b++) begin
            for (int o = 0; o < bank_depth; o++) begin
                model[b][o] = '0;
            end
        end
        rd_pending      = 1'b0;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        checks_at_start = 0;
    end

    // element by element in row-major order, so overlaps see earlier writes
    task automatic apply_add(input logic [inst_width-1:0] w);
        operand_t                   s1;
        operand_t                   s2;
        operand_t                   d;
        int                         rows;
        int                         cols;
        logic [bank_addr_width-1:0] idx;
        logic [data_width-1:0]      a;
        logic [data_width-1:0]      b;
        s1.bank   = w[src1_bank_lsb +: bank_sel_width];
        s1.offset = w[src1_off_lsb +: bank_addr_width];
        s2.bank   = w[src2_bank_lsb +: bank_sel_width];
        s2.offset = w[src2_off_lsb +: bank_addr_width];
        d.bank    = w[dest_bank_lsb +: bank_sel_width];
        d.offset  = w[dest_off_lsb +: bank_addr_width];
        rows      = int'(w[rows_lsb +: dim_width]);
        cols      = int'(w[cols_lsb +: dim_width]);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                idx = bank_addr_width'(r * cols + c);
                a   = model[s1.bank][bank_addr_width'(s1.offset + idx)];
                b   = model[s2.bank][bank_addr_width'(s2.offset + idx)];
                model[d.bank][bank_addr_width'(d.offset + idx)] = a + b;
            end
        end
    endtask

    // --------------------
    // host port watch
    // --------------------
    // inputs settle after the drive delay, so the falling edge is safe
    always @(negedge CLOCK_50) begin
        if (reset) begin
            rd_pending = 1'b0;
        end else begin
            if (rd_pending) begin
                if (!host_rvalid) begin
                    errors++;
                    $display("no read data came back for bank %0d offset %0d",
                             rd_bank, rd_offset);
                end else begin
                    checks++;
                    if (host_rdata !== rd_expect) begin
                        errors++;
                        $display("ERROR host_rdata bank %0d offset 0x%03h: expected 0x%04h, got 0x%04h",
                                 rd_bank, rd_offset, rd_expect, host_rdata);
                    end
                end
            end else if (host_rvalid) begin
                errors++;
                $display("host_rvalid came without a host read before it");
            end
            rd_pending = host_req.valid && !host_req.write;
            rd_bank    = host_req.bank;
            rd_offset  = host_req.offset;
            rd_expect  = model[host_req.bank][host_req.offset];
            if (host_req.valid && host_req.write) begin
                model[host_req.bank][host_req.offset] = host_req.wdata;
            end
            // the host only writes code ahead of fetch, so write order is run order
            if (inst_write && inst_data[opcode_lsb +: opcode_width] == op_add) begin
                apply_add(inst_data);
            end
        end
    end

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %-20s ok      %0d reads checked", tests_run, name,
                     checks - checks_at_start);
        end else begin
            tests_failed++;
            $display("test %0d %-20s FAILED  %0d reads checked, %0d errors", tests_run,
                     name, checks - checks_at_start, errors - errors_at_start);
        end
        errors_at_start = errors;
        checks_at_start = checks;
    endtask

endmodule

/* tests/npu_assertions.sv */
module npu_assertions import npu_pkg::*; (
    input logic     CLOCK_50,
    input logic     reset,
    input mem_req_t engine_req,
    input mem_req_t host_req,
    input logic     host_rvalid,
    input logic     engine_busy,
    input logic     engine_start,
    input logic     engine_done
);

    int fail_count = 0;

    // host only uses the port while the engine is quiet, so no host access is lost
    host_not_during_engine: assert property (
        @(posedge CLOCK_50) disable iff (reset)
        host_req.valid |-> !engine_req.valid
    ) else begin
        fail_count++;
        $error("host request issued while the engine held the memory port");
    end

    // read data for the host only after a host read that got the port
    rvalid_follows_read: assert property (
        @(posedge CLOCK_50) disable iff (reset)
        host_rvalid |-> $past(host_req.valid && !host_req.write && !engine_req.valid)
    ) else begin
        fail_count++;
        $error("host_rvalid without a granted host read one cycle earlier");
    end

    engine_req_when_busy: assert property (
        @(posedge CLOCK_50) disable iff (reset)
        engine_req.valid |-> engine_busy
    ) else begin
        fail_count++;
        $error("engine request valid while the engine is not busy");
    end

    // done follows the last dest write or the start of an empty matrix
    done_after_last_write: assert property (
        @(posedge CLOCK_50) disable iff (reset)
        engine_done |-> $past((engine_req.valid && engine_req.write) || engine_start)
    ) else begin
        fail_count++;
        $error("engine done without a dest write or an empty start one cycle earlier");
    end

endmodule

/* design/npu_top.sv */
module npu_top import npu_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       reset,
    input  logic                       inst_write,
    input  logic [inst_addr_width-1:0] inst_addr,
    input  logic [inst_width-1:0]      inst_data,
    input  mem_req_t                   host_req,
    output logic [data_width-1:0]      host_rdata,
    output logic                       host_rvalid,
    output logic                       npu_idle
);

    // instruction path
    logic [inst_addr_width-1:0] fetch_addr;
    logic [inst_width-1:0]      fetch_word;
    logic                       fetch_valid;
    logic [inst_width-1:0]      fetch_inst;
    logic                       dispatch_hold;

    // engine and memory
    logic                       start;
    matrix_desc_t               desc;
    logic                       engine_busy;
    logic                       engine_done;
    mem_req_t                   engine_req;
    mem_req_t                   mem_req;
    logic [data_width-1:0]      engine_rdata;
    logic [data_width-1:0]      mem_rdata;

    inst_memory i_inst_memory (
        .CLOCK_50   (CLOCK_50),
        .inst_write (inst_write),
        .inst_addr  (inst_addr),
        .inst_data  (inst_data),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word)
    );

    fetch_unit i_fetch_unit (
        .CLOCK_50      (CLOCK_50),
        .reset         (reset),
        .fetch_word    (fetch_word),
        .dispatch_hold (dispatch_hold),
        .engine_busy   (engine_busy),
        .fetch_addr    (fetch_addr),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .npu_idle      (npu_idle)
    );

    dispatch_unit i_dispatch_unit (
        .CLOCK_50      (CLOCK_50),
        .reset         (reset),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .engine_busy   (engine_busy),
        .dispatch_hold (dispatch_hold),
        .start         (start),
        .desc          (desc),
        .pending       ()
    );

    matrix_add_engine i_matrix_add_engine (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .start      (start),
        .desc       (desc),
        .mem_rdata  (engine_rdata),
        .engine_req (engine_req),
        .busy       (engine_busy),
        .done       (engine_done)
    );

    bank_arbiter i_bank_arbiter (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .engine_req   (engine_req),
        .host_req     (host_req),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .host_rdata   (host_rdata),
        .host_rvalid  (host_rvalid),
        .engine_rdata (engine_rdata)
    );

    scratch_memory i_scratch_memory (
        .CLOCK_50  (CLOCK_50),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

/* design/scratch_memory.sv */
module scratch_memory import npu_pkg::*; (
    input  logic                  CLOCK_50,
    input  mem_req_t              mem_req,
    output logic [data_width-1:0] mem_rdata
);

    logic [data_width-1:0]     bank_rdata [num_banks];
    logic [bank_sel_width-1:0] rd_bank_q;

    genvar b;
    generate
        for (b = 0; b < num_banks; b++) begin : g_bank
            logic [data_width-1:0] bank_mem [bank_depth];
            logic [data_width-1:0] rdata_q;
            logic                  we;

            initial begin
                for (int i = 0; i < bank_depth; i++) begin
                    bank_mem[i] = '0;
                end
            end

            assign we = mem_req.valid && mem_req.write
                     && (mem_req.bank == bank_sel_width'(b));

            always_ff @(posedge CLOCK_50) begin
                if (we) begin
                    bank_mem[mem_req.offset] <= mem_req.wdata;
                end
                rdata_q <= bank_mem[mem_req.offset];
            end

            assign bank_rdata[b] = rdata_q;
        end
    endgenerate

    // bank of the read issued last cycle
    always_ff @(posedge CLOCK_50) begin
        rd_bank_q <= mem_req.bank;
    end

    assign mem_rdata = bank_rdata[rd_bank_q];

endmodule

/* design/bank_arbiter.sv */
module bank_arbiter import npu_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  reset,
    input  mem_req_t              engine_req,
    input  mem_req_t              host_req,
    input  logic [data_width-1:0] mem_rdata,
    output mem_req_t              mem_req,
    output logic [data_width-1:0] host_rdata,
    output logic                  host_rvalid,
    output logic [data_width-1:0] engine_rdata
);

    logic host_granted;
    logic engine_rd_q;

    // engine always wins, a host request in a busy cycle is lost
    assign host_granted = host_req.valid && !engine_req.valid;

    always_comb begin
        if (engine_req.valid) begin
            mem_req = engine_req;
        end else begin
            mem_req = host_req;
        end
    end

    // remember who owns the read data of the next cycle
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            host_rvalid <= 1'b0;
            engine_rd_q <= 1'b0;
        end else begin
            host_rvalid <= host_granted && !host_req.write;
            engine_rd_q <= engine_req.valid && !engine_req.write;
        end
    end

    assign host_rdata   = host_rvalid ? mem_rdata : '0;
    assign engine_rdata = engine_rd_q ? mem_rdata : '0;

endmodule

/* design/matrix_add_engine.sv */
module matrix_add_engine import npu_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  reset,
    input  logic                  start,
    input  matrix_desc_t          desc,
    input  logic [data_width-1:0] mem_rdata,
    output mem_req_t              engine_req,
    output logic                  busy,
    output logic                  done
);

    typedef enum logic [2:0] {
        s_idle,
        s_rd1,
        s_rd2,
        s_wr,
        s_done
    } state_t;

    state_t                     state;
    matrix_desc_t               desc_q;
    logic [dim_width-1:0]       row_cnt;
    logic [dim_width-1:0]       col_cnt;
    logic [data_width-1:0]      src1_q;
    logic [bank_addr_width-1:0] elem_idx;
    logic                       last_col;
    logic                       last_elem;

    // row-major position, wraps with the offset add
    assign elem_idx  = row_cnt * desc_q.cols + col_cnt;
    assign last_col  = (col_cnt == desc_q.cols - dim_width'(1));
    assign last_elem = last_col && (row_cnt == desc_q.rows - dim_width'(1));

    // --------------------
    // element FSM
    // --------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state   <= s_idle;
            row_cnt <= '0;
            col_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    row_cnt <= '0;
                    col_cnt <= '0;
                    if (start) begin
                        // empty matrix goes straight to done
                        if (desc.rows == '0 || desc.cols == '0) begin
                            state <= s_done;
                        end else begin
                            state <= s_rd1;
                        end
                    end
                end
                s_rd1: state <= s_rd2;
                s_rd2: state <= s_wr;
                s_wr: begin
                    if (last_elem) begin
                        state <= s_done;
                    end else begin
                        state <= s_rd1;
                        if (last_col) begin
                            col_cnt <= '0;
                            row_cnt <= row_cnt + 1'b1;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == s_idle && start) begin
            desc_q <= desc;
        end
        // src1 data arrives while src2 is being requested
        if (state == s_rd2) begin
            src1_q <= mem_rdata;
        end
    end

    always_comb begin
        engine_req = '0;
        case (state)
            s_rd1: begin
                engine_req.valid  = 1'b1;
                engine_req.bank   = desc_q.src1.bank;
                engine_req.offset = desc_q.src1.offset + elem_idx;
            end
            s_rd2: begin
                engine_req.valid  = 1'b1;
                engine_req.bank   = desc_q.src2.bank;
                engine_req.offset = desc_q.src2.offset + elem_idx;
            end
            s_wr: begin
                engine_req.valid  = 1'b1;
                engine_req.write  = 1'b1;
                engine_req.bank   = desc_q.dest.bank;
                engine_req.offset = desc_q.dest.offset + elem_idx;
                engine_req.wdata  = src1_q + mem_rdata;
            end
            default: engine_req = '0;
        endcase
    end

    assign busy = (state != s_idle);
    assign done = (state == s_done);

endmodule

/* design/dispatch_unit.sv */
module dispatch_unit import npu_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  reset,
    input  logic                  fetch_valid,
    input  logic [inst_width-1:0] fetch_inst,
    input  logic                  engine_busy,
    output logic                  dispatch_hold,
    output logic                  start,
    output matrix_desc_t          desc,
    output logic                  pending
);

    logic [inst_width-1:0]   word_q;
    logic                    word_valid;
    logic [opcode_width-1:0] opcode;
    logic                    load_desc;
    matrix_desc_t            decoded;

    always_ff @(posedge CLOCK_50) begin
        if (fetch_valid) begin
            word_q <= fetch_inst;
        end
    end

    // --------------------
    // decode
    // --------------------
    assign opcode = word_q[opcode_lsb +: opcode_width];

    always_comb begin
        decoded.src1.bank   = word_q[src1_bank_lsb +: bank_sel_width];
        decoded.src1.offset = word_q[src1_off_lsb +: bank_addr_width];
        decoded.src2.bank   = word_q[src2_bank_lsb +: bank_sel_width];
        decoded.src2.offset = word_q[src2_off_lsb +: bank_addr_width];
        decoded.dest.bank   = word_q[dest_bank_lsb +: bank_sel_width];
        decoded.dest.offset = word_q[dest_off_lsb +: bank_addr_width];
        decoded.rows        = word_q[rows_lsb +: dim_width];
        decoded.cols        = word_q[cols_lsb +: dim_width];
    end

    always_comb begin
        case (opcode)
            op_add:                   load_desc = word_valid;
            // no execution unit for these
            op_conv, op_pool, op_relu: load_desc = 1'b0;
            default:                  load_desc = 1'b0;
        endcase
    end

    // --------------------
    // hold and issue
    // --------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            word_valid <= 1'b0;
            pending    <= 1'b0;
        end else begin
            word_valid <= fetch_valid;
            if (load_desc) begin
                pending <= 1'b1;
            end else if (start) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (load_desc) begin
            desc <= decoded;
        end
    end

    assign start         = pending && !engine_busy;
    assign dispatch_hold = word_valid || pending;

endmodule

/* design/fetch_unit.sv */
module fetch_unit import npu_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       reset,
    input  logic [inst_width-1:0]      fetch_word,
    input  logic                       dispatch_hold,
    input  logic                       engine_busy,
    output logic [inst_addr_width-1:0] fetch_addr,
    output logic                       fetch_valid,
    output logic [inst_width-1:0]      fetch_inst,
    output logic                       npu_idle
);

    logic [inst_addr_width-1:0] pc;
    logic                       eval_phase;
    logic                       parked;
    logic                       word_nonzero;

    assign word_nonzero = |fetch_word;

    // address phase presents pc, evaluate phase looks at the word
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            pc         <= '0;
            eval_phase <= 1'b0;
            parked     <= 1'b0;
        end else if (!eval_phase) begin
            eval_phase <= 1'b1;
        end else if (!word_nonzero) begin
            // zero word, keep pc and read it again
            parked     <= 1'b1;
            eval_phase <= 1'b0;
        end else begin
            parked <= 1'b0;
            // under back-pressure stay here with the same pc
            if (!dispatch_hold) begin
                pc         <= pc + 1'b1;
                eval_phase <= 1'b0;
            end
        end
    end

    assign fetch_addr  = pc;
    assign fetch_inst  = fetch_word;
    assign fetch_valid = eval_phase && word_nonzero && !dispatch_hold;

    // a word that is about to leave fetch already counts as work
    assign npu_idle = parked
                   && !(eval_phase && word_nonzero)
                   && !dispatch_hold
                   && !engine_busy;

endmodule

/* design/inst_memory.sv */
module inst_memory import npu_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       inst_write,
    input  logic [inst_addr_width-1:0] inst_addr,
    input  logic [inst_width-1:0]      inst_data,
    input  logic [inst_addr_width-1:0] fetch_addr,
    output logic [inst_width-1:0]      fetch_word
);

    logic [inst_width-1:0] inst_mem [inst_depth];

    // empty program, so fetch parks at pc 0
    initial begin
        for (int i = 0; i < inst_depth; i++) begin
            inst_mem[i] = '0;
        end
    end

    // host write port
    always_ff @(posedge CLOCK_50) begin
        if (inst_write) begin
            inst_mem[inst_addr] <= inst_data;
        end
    end

    // fetch side reads every cycle, old data on a same-address write
    always_ff @(posedge CLOCK_50) begin
        fetch_word <= inst_mem[fetch_addr];
    end

endmodule

/* design/npu_pkg.sv */
package npu_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int data_width      = 16;
    localparam int num_banks       = 8;
    localparam int bank_depth      = 1024;
    localparam int bank_addr_width = 10;
    localparam int bank_sel_width  = 3;

    localparam int inst_width      = 128;
    localparam int inst_depth      = 512;
    localparam int inst_addr_width = 9;

    // row and column counts, 0 to 16
    localparam int dim_width       = 5;

    // --------------------
    // instruction word
    // --------------------
    localparam int opcode_width  = 4;
    localparam int opcode_lsb    = 124;
    localparam int src1_bank_lsb = 112;
    localparam int src1_off_lsb  = 96;
    localparam int src2_bank_lsb = 80;
    localparam int src2_off_lsb  = 64;
    localparam int dest_bank_lsb = 48;
    localparam int dest_off_lsb  = 32;
    localparam int rows_lsb      = 8;
    localparam int cols_lsb      = 0;

    // only add is executed, the rest are recognised and dropped
    localparam logic [opcode_width-1:0] op_add  = 4'd1;
    localparam logic [opcode_width-1:0] op_conv = 4'd7;
    localparam logic [opcode_width-1:0] op_pool = 4'd8;
    localparam logic [opcode_width-1:0] op_relu = 4'd10;

    // one matrix location
    typedef struct packed {
        logic [bank_sel_width-1:0]  bank;
        logic [bank_addr_width-1:0] offset;
    } operand_t;

    // decoded add instruction
    typedef struct packed {
        operand_t               src1;
        operand_t               src2;
        operand_t               dest;
        logic [dim_width-1:0]   rows;
        logic [dim_width-1:0]   cols;
    } matrix_desc_t;

    // single scratch access
    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic [bank_sel_width-1:0]  bank;
        logic [bank_addr_width-1:0] offset;
        logic [data_width-1:0]      wdata;
    } mem_req_t;

endpackage
